//--- qnet_trace.txt
# Columns in hex: C op dt1 dt2 dt3 | R and T hdr dt1 dt2 dt3 | P sel value | N cycles
# K credit pulse, U and E expect time_updt_o and cmd_err_o, W wait for c_ready_o
# P sel is 0 id, 1 nn, 2 dt1, 3 dt2, 4 time offset
# Local get_net on a ring of four nodes
C 01 00000000 12345678 00000000
T 01C3FE01 00000001 12345678 00000000
P 0 00000001
R 01C3FE01 00000004 12345678 00000000
W
P 1 00000004
# Received set_net makes this node number 3
R 02C3FE01 00000000 00000000 00040003
T 02C3FE01 00000000 00000000 00040004
P 0 00000003
P 1 00000004
K
K
# updt_off and set_dt addressed to node 3
R 09000601 00001F40 00000000 00000000
U
P 4 00001F40
R 0A000601 CAFE0001 BEEF0002 00000000
P 2 CAFE0001
P 3 BEEF0002
N 14
# get_dt from node 2 gets an answer
R 0B400602 00000000 00000000 00000000
T 0B440403 CAFE0001 BEEF0002 00000000
# Local get_dt to node 2 and the answer
C 0B 00000000 00000000 00020000
T 0B400403 00000000 00000000 00020000
R 0B440602 11112222 33334444 00000000
W
P 2 11112222
P 3 33334444
# No credits left, two local commands queue up
C 0A 55550000 66660000 00050000
N 14
C 09 00000100 00000000 00060000
N 0A
K
T 0A000A03 55550000 66660000 00050000
N 0A
K
T 09000C03 00000100 00000000 00060000
W
K
K
# Unrelated frame while an answer is awaited
C 0B 00000000 00000000 00040000
T 0B400803 00000000 00000000 00040000
R 0A000E02 00000001 00000002 00000000
E
N 0A
R 0B440604 77778888 9999AAAA 00000000
W
P 2 77778888
P 3 9999AAAA

//--- qnet_node.f
qnet_frame_pkg.sv
qnet_node_pkg.sv
qnet_cmd_if.sv
qnet_tx_if.sv
qnet_cmd_arbiter.sv
qnet_cmd_exec.sv
qnet_tx_credit.sv
qnet_node.sv
tb_qnet_node.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_qnet_node
FILELIST  ?= qnet_node.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_qnet_node.sv
`timescale 1ns/1ps

module tb_qnet_node;

   localparam int unsigned TX_CREDITS = 2;
   localparam int CLK_HALF    = 2;
   localparam int RST_CYCLES  = 10;
   localparam int STEP_CYCLES = 200;
   // Longest wait for any single DUT reaction
   localparam int WAIT_LIMIT  = 100;
   // Idle link cycles ahead of each received frame
   localparam int RX_GAP      = 4;
   localparam string TRACE_FILE = "qnet_trace.txt";

   typedef struct packed {
      logic [7:0]  kind;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] d;
   } step_t;

   logic         t_clk;
   logic         t_aresetn;
   logic         c_cmd_i;
   logic [4:0]   c_op_i;
   logic [31:0]  c_dt1_i;
   logic [31:0]  c_dt2_i;
   logic [31:0]  c_dt3_i;
   logic         c_ready_o;
   logic         rx_valid_i;
   logic [127:0] rx_frame_i;
   logic         tx_credit_i;
   logic         tx_valid_o;
   logic [127:0] tx_frame_o;
   logic [8:0]   param_id_o;
   logic [8:0]   param_nn_o;
   logic [31:0]  param_dt1_o;
   logic [31:0]  param_dt2_o;
   logic [31:0]  time_off_dt_o;
   logic         time_updt_o;
   logic         cmd_err_o;

   step_t        steps[$];
   logic [127:0] tx_seen[$];
   int unsigned  trace_len;
   int unsigned  checks;
   int unsigned  errors;
   // Index 0 counts time_updt_o, index 1 counts cmd_err_o
   int unsigned  pulse_seen[2];
   int unsigned  pulse_used[2];
   // Local command still waits for its response frame
   bit           answer_due;

   qnet_node #(
      .TX_CREDITS (TX_CREDITS)
   ) dut_i (
      .t_clk         (t_clk),
      .t_aresetn     (t_aresetn),
      .c_cmd_i       (c_cmd_i),
      .c_op_i        (c_op_i),
      .c_dt1_i       (c_dt1_i),
      .c_dt2_i       (c_dt2_i),
      .c_dt3_i       (c_dt3_i),
      .c_ready_o     (c_ready_o),
      .rx_valid_i    (rx_valid_i),
      .rx_frame_i    (rx_frame_i),
      .tx_credit_i   (tx_credit_i),
      .tx_valid_o    (tx_valid_o),
      .tx_frame_o    (tx_frame_o),
      .param_id_o    (param_id_o),
      .param_nn_o    (param_nn_o),
      .param_dt1_o   (param_dt1_o),
      .param_dt2_o   (param_dt2_o),
      .time_off_dt_o (time_off_dt_o),
      .time_updt_o   (time_updt_o),
      .cmd_err_o     (cmd_err_o)
   );

   initial t_clk = 1'b0;
   always #(CLK_HALF) t_clk = ~t_clk;

   // Link and pulse monitor, sampled mid-cycle
   always @(negedge t_clk) begin
      if (t_aresetn) begin
         if (tx_valid_o)
            tx_seen.push_back(tx_frame_o);
         if (time_updt_o)
            pulse_seen[0]++;
         if (cmd_err_o)
            pulse_seen[1]++;
      end
   end

   ////////////////////////////////////////////////////////////
   // Trace reading and parameter lookup
   task automatic load_trace();
      int          fd;
      int          cnt;
      string       line;
      logic [7:0]  kind;
      logic [31:0] a, b, c, d;
      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0) begin
         errors++;
         $display("Cannot open trace file %s", TRACE_FILE);
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         cnt  = $fgets(line, fd);
         kind = (cnt > 0) ? line.getc(0) : 8'h00;
         // Step lines start with an upper case letter
         if (kind >= "A" && kind <= "Z") begin
            a   = '0;
            b   = '0;
            c   = '0;
            d   = '0;
            cnt = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d);
            steps.push_back({kind, a, b, c, d});
         end
      end
      $fclose(fd);
   endtask

   function automatic logic [31:0] param_value(input int sel);
      case (sel)
         0:       return {23'd0, param_id_o};
         1:       return {23'd0, param_nn_o};
         2:       return param_dt1_o;
         3:       return param_dt2_o;
         default: return time_off_dt_o;
      endcase
   endfunction

   function automatic string param_name(input int sel);
      case (sel)
         0:       return "param_id_o";
         1:       return "param_nn_o";
         2:       return "param_dt1_o";
         3:       return "param_dt2_o";
         default: return "time_off_dt_o";
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Drivers
   task automatic wait_ready();
      int n;
      n = 0;
      @(negedge t_clk);
      while (!c_ready_o && n < WAIT_LIMIT) begin
         @(negedge t_clk);
         n++;
      end
      checks++;
      assert (c_ready_o) else begin
         errors++;
         $display("c_ready_o did not return within %0d cycles", WAIT_LIMIT);
      end
      if (c_ready_o)
         answer_due = 1'b0;
   endtask

   task automatic drive_cmd(input step_t s);
      wait_ready();
      @(posedge t_clk);
      c_cmd_i <= 1'b1;
      c_op_i  <= s.a[4:0];
      c_dt1_i <= s.b;
      c_dt2_i <= s.c;
      c_dt3_i <= s.d;
      @(posedge t_clk);
      c_cmd_i <= 1'b0;
      // get_net, set_net and get_dt ask for a response
      answer_due = (s.a[4:0] == 5'h01) || (s.a[4:0] == 5'h02) ||
                   (s.a[4:0] == 5'h0B);
      @(negedge t_clk);
      checks++;
      assert (!c_ready_o) else begin
         errors++;
         $display("c_ready_o stayed high after a command was captured");
      end
   endtask

   task automatic drive_rx(input step_t s);
      @(negedge t_clk);
      if (answer_due) begin
         checks++;
         assert (!c_ready_o) else begin
            errors++;
            $display("c_ready_o returned before the response frame arrived");
         end
      end
      repeat (RX_GAP) @(posedge t_clk);
      rx_valid_i <= 1'b1;
      rx_frame_i <= {s.a, s.b, s.c, s.d};
      @(posedge t_clk);
      rx_valid_i <= 1'b0;
   endtask

   task automatic pulse_credit();
      @(posedge t_clk);
      tx_credit_i <= 1'b1;
      @(posedge t_clk);
      tx_credit_i <= 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // Checkers
   task automatic expect_frame(input step_t s);
      logic [127:0] exp;
      logic [127:0] got;
      int           n;
      exp = {s.a, s.b, s.c, s.d};
      n   = 0;
      while (tx_seen.size() == 0 && n < WAIT_LIMIT) begin
         @(posedge t_clk);
         n++;
      end
      checks++;
      assert (tx_seen.size() != 0) else begin
         errors++;
         $display("No frame on the transmit port within %0d cycles", WAIT_LIMIT);
      end
      if (tx_seen.size() != 0) begin
         got = tx_seen.pop_front();
         assert (got == exp) else begin
            errors++;
            $display("ERR tx_frame_o: got %h, expected %h", got, exp);
         end
      end
   endtask

   task automatic expect_param(input step_t s);
      int n;
      n = 0;
      @(negedge t_clk);
      while (param_value(int'(s.a)) != s.b && n < WAIT_LIMIT) begin
         @(negedge t_clk);
         n++;
      end
      checks++;
      assert (param_value(int'(s.a)) == s.b) else begin
         errors++;
         $display("ERR %s: got %h, expected %h", param_name(int'(s.a)),
                  param_value(int'(s.a)), s.b);
      end
   endtask

   task automatic expect_pulse(input int idx);
      int n;
      n = 0;
      while (pulse_seen[idx] == pulse_used[idx] && n < WAIT_LIMIT) begin
         @(posedge t_clk);
         n++;
      end
      checks++;
      assert (pulse_seen[idx] > pulse_used[idx]) else begin
         errors++;
         $display("No pulse on %s within %0d cycles",
                  (idx == 0) ? "time_updt_o" : "cmd_err_o", WAIT_LIMIT);
      end
      if (pulse_seen[idx] > pulse_used[idx])
         pulse_used[idx]++;
   endtask

   // Link must stay silent for the whole window
   task automatic expect_quiet(input int cycles);
      repeat (cycles) @(posedge t_clk);
      checks++;
      assert (tx_seen.size() == 0) else begin
         errors++;
         $display("Unexpected frame on the transmit port: %h", tx_seen[0]);
      end
   endtask

   task automatic run_step(input step_t s);
      case (s.kind)
         "C": drive_cmd(s);
         "R": drive_rx(s);
         "K": pulse_credit();
         "T": expect_frame(s);
         "P": expect_param(s);
         "U": expect_pulse(0);
         "E": expect_pulse(1);
         "N": expect_quiet(int'(s.a));
         "W": wait_ready();
         default: begin
            errors++;
            $display("Unknown trace step kind %s", s.kind);
         end
      endcase
   endtask

   task automatic finish_run(input bit timed_out);
      $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
      if (errors == 0 && !timed_out) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   initial begin
      t_aresetn   = 1'b0;
      c_cmd_i     = 1'b0;
      c_op_i      = '0;
      c_dt1_i     = '0;
      c_dt2_i     = '0;
      c_dt3_i     = '0;
      rx_valid_i  = 1'b0;
      rx_frame_i  = '0;
      tx_credit_i = 1'b0;
      load_trace();
      trace_len = steps.size();
      repeat (RST_CYCLES) @(posedge t_clk);
      t_aresetn <= 1'b1;
      @(posedge t_clk);
      foreach (steps[i])
         run_step(steps[i]);
      // Late frames and pulses still reach the monitor
      repeat (RX_GAP) @(posedge t_clk);
      checks++;
      assert (trace_len != 0) else begin
         errors++;
         $display("Trace holds no steps");
      end
      assert (tx_seen.size() == 0) else begin
         errors++;
         $display("%0d transmitted frames were not expected", tx_seen.size());
      end
      assert (pulse_seen[0] == pulse_used[0] && pulse_seen[1] == pulse_used[1]) else begin
         errors++;
         $display("Unexpected pulses on time_updt_o or cmd_err_o");
      end
      finish_run(1'b0);
   end

   // Watchdog
   initial begin
      wait (trace_len != 0);
      repeat (trace_len * STEP_CYCLES + RST_CYCLES) @(posedge t_clk);
      $display("Watchdog stopped the run after %0d cycles",
               trace_len * STEP_CYCLES + RST_CYCLES);
      finish_run(1'b1);
   end

endmodule

//--- qnet_node.sv
`timescale 1ns/1ps

module qnet_node
   import qnet_frame_pkg::*;
   import qnet_node_pkg::*;
#(
   parameter int unsigned TX_CREDITS = 4
) (
   input  logic         t_clk,
   input  logic         t_aresetn,
   // Processor port
   input  logic         c_cmd_i,
   input  logic [4:0]   c_op_i,
   input  logic [31:0]  c_dt1_i,
   input  logic [31:0]  c_dt2_i,
   input  logic [31:0]  c_dt3_i,
   output logic         c_ready_o,
   // Link
   input  logic         rx_valid_i,
   input  logic [127:0] rx_frame_i,
   input  logic         tx_credit_i,
   output logic         tx_valid_o,
   output logic [127:0] tx_frame_o,
   // Node parameters
   output logic [8:0]   param_id_o,
   output logic [8:0]   param_nn_o,
   output logic [31:0]  param_dt1_o,
   output logic [31:0]  param_dt2_o,
   output logic [31:0]  time_off_dt_o,
   output logic         time_updt_o,
   output logic         cmd_err_o
);

   qnet_params_t params;

   qnet_cmd_if cmd_if ();
   qnet_tx_if  tx_if ();

   qnet_cmd_arbiter arb_i (
      .t_clk      (t_clk),
      .t_aresetn  (t_aresetn),
      .c_cmd_i    (c_cmd_i),
      .c_op_i     (qnet_op_t'(c_op_i)),
      .c_dt1_i    (c_dt1_i),
      .c_dt2_i    (c_dt2_i),
      .c_dt3_i    (c_dt3_i),
      .rx_valid_i (rx_valid_i),
      .rx_frame_i (rx_frame_i),
      .node_id_i  (params.id),
      .c_ready_o  (c_ready_o),
      .cmd        (cmd_if.arb)
   );

   qnet_cmd_exec exec_i (
      .t_clk       (t_clk),
      .t_aresetn   (t_aresetn),
      .cmd         (cmd_if.exec),
      .tx          (tx_if.exec),
      .params_o    (params),
      .time_updt_o (time_updt_o),
      .cmd_err_o   (cmd_err_o)
   );

   qnet_tx_credit #(
      .TX_CREDITS (TX_CREDITS)
   ) tx_i (
      .t_clk       (t_clk),
      .t_aresetn   (t_aresetn),
      .tx_credit_i (tx_credit_i),
      .tx          (tx_if.txr),
      .tx_valid_o  (tx_valid_o),
      .tx_frame_o  (tx_frame_o)
   );

   assign param_id_o    = params.id;
   assign param_nn_o    = params.nn;
   assign param_dt1_o   = params.dt1;
   assign param_dt2_o   = params.dt2;
   assign time_off_dt_o = params.off;

endmodule

//--- qnet_tx_credit.sv
`timescale 1ns/1ps

module qnet_tx_credit
   import qnet_frame_pkg::*;
#(
   parameter int unsigned TX_CREDITS = 4
) (
   input  logic        t_clk,
   input  logic        t_aresetn,
   input  logic        tx_credit_i,
   qnet_tx_if.txr      tx,
   output logic        tx_valid_o,
   output qnet_frame_t tx_frame_o
);

   // One spare bit so an underflow shows up as a large count
   localparam int CNT_W = 5;

   logic             full_q;
   logic [CNT_W-1:0] cnt_q;
   qnet_frame_t      frame_q;

   assign tx.space   = !full_q;
   // Buffered frame leaves as soon as a credit is there
   assign tx_valid_o = full_q && (cnt_q != '0);
   assign tx_frame_o = frame_q;

   always_ff @(posedge t_clk) begin
      if (!t_aresetn) begin
         full_q <= 1'b0;
         cnt_q  <= CNT_W'(TX_CREDITS);
      end else begin
         if (tx.valid)
            full_q <= 1'b1;
         else if (tx_valid_o)
            full_q <= 1'b0;
         cnt_q <= cnt_q - CNT_W'(tx_valid_o) + CNT_W'(tx_credit_i);
      end
   end

   always_ff @(posedge t_clk) begin
      if (tx.valid)
         frame_q <= tx.frame;
   end

   ////////////////////////////////////////////////////////////
   // Credit bookkeeping toward the link
   a_cnt_range: assert property (
      @(posedge t_clk) disable iff (!t_aresetn) cnt_q <= CNT_W'(TX_CREDITS)
   ) else $error("tx credit count out of range: %0d", cnt_q);

   a_credit_return: assert property (
      @(posedge t_clk) disable iff (!t_aresetn)
         tx_credit_i && !tx_valid_o |-> cnt_q < CNT_W'(TX_CREDITS)
   ) else $error("link returned a credit that was never used");

endmodule

//--- qnet_cmd_exec.sv
`timescale 1ns/1ps

module qnet_cmd_exec
   import qnet_frame_pkg::*;
   import qnet_node_pkg::*;
(
   input  logic         t_clk,
   input  logic         t_aresetn,
   qnet_cmd_if.exec     cmd,
   qnet_tx_if.exec      tx,
   output qnet_params_t params_o,
   output logic         time_updt_o,
   output logic         cmd_err_o
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_SEND,
      S_PUSH,
      S_END
   } exec_st_t;

   exec_st_t     state_q;
   qnet_params_t params_q;
   qnet_params_t params_d;
   logic         wfr_q;
   logic         wfr_d;
   qnet_frame_t  frame_d;
   qnet_frame_t  frame_q;
   logic         send_d;
   logic         updt_d;
   logic         err_d;
   logic         dec;
   logic         dst_hit;
   logic         is_resp;

   assign dec     = (state_q == S_IDLE) && cmd.req;
   assign dst_hit = (cmd.hdr.dst == params_q.id);
   assign is_resp = qnet_is_resp(cmd.hdr, params_q.id);

   ////////////////////////////////////////////////////////////
   // Command decode
   always_comb begin
      params_d    = params_q;
      wfr_d       = wfr_q;
      send_d      = 1'b0;
      updt_d      = 1'b0;
      err_d       = 1'b0;
      // Default is to pass the frame on as it came
      frame_d.hdr = cmd.hdr;
      frame_d.dt1 = cmd.dt1;
      frame_d.dt2 = cmd.dt2;
      frame_d.dt3 = cmd.dt3;
      if (cmd.src == SRC_LOC) begin
         send_d = 1'b1;
         wfr_d  = cmd.hdr.flg[FLG_RESP_REQ];
         case (cmd.hdr.op)
            OP_GET_NET: begin
               // Originator of discovery is node 1
               params_d.id = 9'd1;
               frame_d.dt1 = 32'd1;
            end
            OP_SET_NET:
               frame_d.dt3 = {7'd0, params_q.nn, 7'd0, params_q.id + 9'd1};
            default: ;
         endcase
      end else if (wfr_q) begin
         if (is_resp) begin
            wfr_d = 1'b0;
            case (cmd.hdr.op)
               OP_GET_NET: params_d.nn = cmd.dt1[8:0];
               OP_GET_DT: begin
                  params_d.dt1 = cmd.dt1;
                  params_d.dt2 = cmd.dt2;
               end
               default: ;
            endcase
         end else begin
            // Unexpected frame while waiting, dropped
            err_d = 1'b1;
         end
      end else begin
         send_d = 1'b1;
         case (cmd.hdr.op)
            OP_GET_NET: frame_d.dt1 = cmd.dt1 + 32'd1;
            OP_SET_NET: begin
               params_d.nn      = cmd.dt3[24:16];
               params_d.id      = cmd.dt3[8:0];
               frame_d.dt3[8:0] = cmd.dt3[8:0] + 9'd1;
            end
            OP_UPDT_OFF: if (dst_hit) begin
               send_d       = 1'b0;
               updt_d       = 1'b1;
               params_d.off = cmd.dt1;
            end
            OP_SET_DT: if (dst_hit) begin
               send_d       = 1'b0;
               params_d.dt1 = cmd.dt1;
               params_d.dt2 = cmd.dt2;
            end
            OP_GET_DT: if (dst_hit) begin
               // Answer goes back to the asking node
               frame_d.hdr.flg[FLG_ANS] = 1'b1;
               frame_d.hdr.dst          = cmd.hdr.src;
               frame_d.hdr.src          = params_q.id;
               frame_d.dt1              = params_q.dt1;
               frame_d.dt2              = params_q.dt2;
               frame_d.dt3              = '0;
            end
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // State, parameters and pulses
   always_ff @(posedge t_clk) begin
      if (!t_aresetn) begin
         state_q     <= S_IDLE;
         params_q    <= '0;
         wfr_q       <= 1'b0;
         time_updt_o <= 1'b0;
         cmd_err_o   <= 1'b0;
      end else begin
         time_updt_o <= 1'b0;
         cmd_err_o   <= 1'b0;
         case (state_q)
            S_IDLE: if (cmd.req) begin
               params_q    <= params_d;
               wfr_q       <= wfr_d;
               time_updt_o <= updt_d;
               cmd_err_o   <= err_d;
               state_q     <= send_d ? S_SEND : S_END;
            end
            // Stall here until the transmit buffer is free
            S_SEND: if (tx.space) state_q <= S_PUSH;
            // Frame handed to the transmit buffer
            S_PUSH: state_q <= S_END;
            default: state_q <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge t_clk) begin
      if (dec && send_d)
         frame_q <= frame_d;
   end

   assign tx.valid  = (state_q == S_PUSH);
   assign tx.frame  = frame_q;
   assign cmd.done  = (state_q == S_END);
   assign params_o  = params_q;

   a_tx_space: assert property (
      @(posedge t_clk) disable iff (!t_aresetn) tx.valid |-> tx.space
   ) else $error("tx valid while transmit buffer is full");

   // Arbiter must release the command right after done
   a_cmd_release: assert property (
      @(posedge t_clk) disable iff (!t_aresetn) cmd.done |=> !cmd.req
   ) else $error("cmd req still high after done");

endmodule

//--- qnet_cmd_arbiter.sv
`timescale 1ns/1ps

module qnet_cmd_arbiter
   import qnet_frame_pkg::*;
   import qnet_node_pkg::*;
(
   input  logic                 t_clk,
   input  logic                 t_aresetn,
   input  logic                 c_cmd_i,
   input  qnet_op_t             c_op_i,
   input  logic [31:0]          c_dt1_i,
   input  logic [31:0]          c_dt2_i,
   input  logic [31:0]          c_dt3_i,
   input  logic                 rx_valid_i,
   input  qnet_frame_t          rx_frame_i,
   input  logic [QNET_ID_W-1:0] node_id_i,
   output logic                 c_ready_o,
   qnet_cmd_if.arb              cmd
);

   localparam logic [5:0] FLG_LOC_NET = 6'b110000;
   localparam logic [5:0] FLG_LOC_GET = 6'b010000;

   logic        loc_pend;
   logic        loc_wait;
   logic        net_pend;
   qnet_hdr_t   loc_hdr_d;
   qnet_hdr_t   loc_hdr;
   logic [31:0] loc_dt1, loc_dt2, loc_dt3;
   qnet_frame_t net_frame;

   // Header for a processor command
   always_comb begin
      loc_hdr_d     = '0;
      loc_hdr_d.op  = c_op_i;
      loc_hdr_d.dst = c_dt3_i[24:16];
      loc_hdr_d.src = node_id_i;
      case (c_op_i)
         OP_GET_NET: begin
            loc_hdr_d.flg = FLG_LOC_NET;
            loc_hdr_d.dst = NODE_BCAST;
            loc_hdr_d.src = 9'd1;
         end
         OP_SET_NET: begin
            loc_hdr_d.flg = FLG_LOC_NET;
            loc_hdr_d.dst = NODE_BCAST;
         end
         OP_GET_DT: loc_hdr_d.flg = FLG_LOC_GET;
         default: ;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Pending flags and selection
   always_ff @(posedge t_clk) begin
      if (!t_aresetn) begin
         loc_pend <= 1'b0;
         loc_wait <= 1'b0;
         net_pend <= 1'b0;
         cmd.req  <= 1'b0;
         cmd.src  <= SRC_LOC;
      end else begin
         if (cmd.done) begin
            cmd.req <= 1'b0;
            if (cmd.src == SRC_LOC) begin
               loc_pend <= 1'b0;
               // Processor stays blocked until the answer is back
               loc_wait <= loc_hdr.flg[FLG_RESP_REQ];
            end else begin
               net_pend <= 1'b0;
               if (loc_wait && qnet_is_resp(net_frame.hdr, node_id_i))
                  loc_wait <= 1'b0;
            end
         end else if (!cmd.req && (loc_pend || net_pend)) begin
            cmd.req <= 1'b1;
            // Local command first
            cmd.src <= loc_pend ? SRC_LOC : SRC_NET;
         end
         if (c_cmd_i)
            loc_pend <= 1'b1;
         if (rx_valid_i)
            net_pend <= 1'b1;
      end
   end

   always_ff @(posedge t_clk) begin
      if (c_cmd_i) begin
         loc_hdr <= loc_hdr_d;
         loc_dt1 <= c_dt1_i;
         loc_dt2 <= c_dt2_i;
         loc_dt3 <= c_dt3_i;
      end
      if (rx_valid_i)
         net_frame <= rx_frame_i;
   end

   assign c_ready_o = !loc_pend && !loc_wait;

   // Payload toward the executor
   always_comb begin
      if (cmd.src == SRC_LOC) begin
         cmd.hdr = loc_hdr;
         cmd.dt1 = loc_dt1;
         cmd.dt2 = loc_dt2;
         cmd.dt3 = loc_dt3;
      end else begin
         cmd.hdr = net_frame.hdr;
         cmd.dt1 = net_frame.dt1;
         cmd.dt2 = net_frame.dt2;
         cmd.dt3 = net_frame.dt3;
      end
   end

   // Receive side has one slot and no back-pressure
   a_rx_no_overrun: assert property (
      @(posedge t_clk) disable iff (!t_aresetn) rx_valid_i |-> !net_pend
   ) else $error("rx frame arrived while another one is pending");

endmodule

//--- qnet_tx_if.sv
`timescale 1ns/1ps

// Outgoing frame from executor to transmit buffer
interface qnet_tx_if
   import qnet_frame_pkg::*;
();

   logic        valid;
   qnet_frame_t frame;
   // High while the transmit buffer is empty
   logic        space;

   modport exec (
      output valid, frame,
      input  space
   );

   modport txr (
      input  valid, frame,
      output space
   );

endinterface

//--- qnet_cmd_if.sv
`timescale 1ns/1ps

// Command handoff from arbiter to executor.
// Payload holds while req is high, req drops after done
interface qnet_cmd_if
   import qnet_frame_pkg::*;
   import qnet_node_pkg::*;
();

   logic        req;
   qnet_src_t   src;
   qnet_hdr_t   hdr;
   logic [31:0] dt1;
   logic [31:0] dt2;
   logic [31:0] dt3;
   logic        done;

   modport arb (
      output req, src, hdr, dt1, dt2, dt3,
      input  done
   );

   modport exec (
      input  req, src, hdr, dt1, dt2, dt3,
      output done
   );

endinterface

//--- qnet_node_pkg.sv
package qnet_node_pkg;

   import qnet_frame_pkg::*;

   // Parameter registers kept by one node
   typedef struct packed {
      logic [QNET_ID_W-1:0] id;
      logic [QNET_ID_W-1:0] nn;
      logic [31:0]          dt1;
      logic [31:0]          dt2;
      logic [31:0]          off;
   } qnet_params_t;

   // Where the command in execution came from
   typedef enum logic {
      SRC_LOC,
      SRC_NET
   } qnet_src_t;

endpackage

//--- qnet_frame_pkg.sv
package qnet_frame_pkg;

   // Node address width and the broadcast address
   localparam int QNET_ID_W = 9;
   localparam logic [QNET_ID_W-1:0] NODE_BCAST = '1;

   // Flag bit positions inside the 6-bit flag field
   localparam int FLG_RESP_REQ = 4;
   localparam int FLG_ANS      = 0;

   // Opcodes carried in the header
   typedef enum logic [4:0] {
      OP_GET_NET  = 5'd1,
      OP_SET_NET  = 5'd2,
      OP_UPDT_OFF = 5'd9,
      OP_SET_DT   = 5'd10,
      OP_GET_DT   = 5'd11
   } qnet_op_t;

   // 32-bit frame header
   typedef struct packed {
      logic [2:0]           zero;
      qnet_op_t             op;
      logic [5:0]           flg;
      logic [QNET_ID_W-1:0] dst;
      logic [QNET_ID_W-1:0] src;
   } qnet_hdr_t;

   // 128-bit frame, header in the top word
   typedef struct packed {
      qnet_hdr_t   hdr;
      logic [31:0] dt1;
      logic [31:0] dt2;
      logic [31:0] dt3;
   } qnet_frame_t;

   // Frame closes a command this node started
   function automatic logic qnet_is_resp(qnet_hdr_t hdr, logic [QNET_ID_W-1:0] id);
      return ((hdr.src == id) && hdr.flg[FLG_RESP_REQ]) ||
             ((hdr.dst == id) && hdr.flg[FLG_ANS]);
   endfunction

endpackage
